// ==== source/term_geom_pkg.sv ====
`default_nettype none

package term_geom_pkg;

    // Glyph cell
    localparam int GLYPH_W      = 8;
    localparam int GLYPH_H      = 16;
    localparam int GLYPH_PIXELS = GLYPH_W * GLYPH_H;
    localparam int PIX_IDX_W    = 7;
    localparam logic [PIX_IDX_W-1:0] LAST_PIX = PIX_IDX_W'(GLYPH_PIXELS - 1);

    // Screen in cells
    localparam int COLS     = 40;
    localparam int ROWS     = 15;
    localparam int COL_W    = 6;
    localparam int ROW_W    = 4;
    localparam int SCROLL_W = 6;   // Wraps at 64
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(COLS - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(ROWS - 1);

    // Screen in pixels
    localparam int PIX_X_W = 9;
    localparam int PIX_Y_W = 8;

    // Printable range and font storage
    localparam logic [6:0] FIRST_PRINT = 7'h20;
    localparam logic [6:0] LAST_PRINT  = 7'h7E;
    localparam int GLYPH_COUNT = 95;
    localparam int FONT_ADDR_W = 11;   // Glyph index * 16 + row
    localparam int FONT_DEPTH  = GLYPH_COUNT * GLYPH_H;
    localparam logic [FONT_ADDR_W-1:0] FONT_END = FONT_ADDR_W'(FONT_DEPTH);

endpackage

`default_nettype wire

// ==== source/term_host_pkg.sv ====
`default_nettype none

package term_host_pkg;

    localparam int APB_ADDR_W = 14;

    // Register map
    localparam logic [APB_ADDR_W-1:0] ADDR_CHAR   = 14'h0000;  // Write only, code in [6:0]
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 14'h0004;  // Read only

    // Font rows live above this bit, row index in paddr[12:2]
    localparam int FONT_REGION_BIT = 13;

    // Control codes understood by the cursor stage
    localparam logic [6:0] C_BACKSPACE = 7'h08;
    localparam logic [6:0] C_ENTER     = 7'h0A;
    localparam logic [6:0] C_HOME      = 7'h0D;
    localparam logic [6:0] C_UP        = 7'h11;
    localparam logic [6:0] C_LEFT      = 7'h12;
    localparam logic [6:0] C_DOWN      = 7'h13;
    localparam logic [6:0] C_RIGHT     = 7'h14;
    localparam logic [6:0] C_END       = 7'h17;

endpackage

`default_nettype wire

// ==== source/term_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module term_apb_regs (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [term_host_pkg::APB_ADDR_W-1:0]    paddr,
    input  logic [31:0]                             pwdata,
    input  logic                                    code_ready,
    input  logic                                    engine_busy,
    input  logic [term_geom_pkg::COL_W-1:0]         cur_col,
    input  logic [term_geom_pkg::ROW_W-1:0]         cur_row,
    input  logic [term_geom_pkg::SCROLL_W-1:0]      scroll_line,
    output logic [31:0]                             prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    code_valid,
    output logic [6:0]                              code,
    output logic                                    font_we,
    output logic [term_geom_pkg::FONT_ADDR_W-1:0]   font_addr,
    output logic [term_geom_pkg::GLYPH_W-1:0]       font_data
);

    logic access;
    logic hit_char, hit_status, hit_font;
    logic char_accept;
    logic busy;

    assign access     = psel & penable;
    assign hit_font   = paddr[term_host_pkg::FONT_REGION_BIT];
    assign hit_char   = !hit_font && (paddr == term_host_pkg::ADDR_CHAR);
    assign hit_status = !hit_font && (paddr == term_host_pkg::ADDR_STATUS);

    // Character writes wait here while the holding register is full
    assign char_accept = access && pwrite && hit_char && !code_valid;
    assign pready      = access && !(pwrite && hit_char && code_valid);
    assign pslverr     = access && ((pwrite && hit_status) || !(hit_char || hit_status || hit_font));

    // Font rows go straight through in the access cycle
    assign font_we   = access && pwrite && hit_font;
    assign font_addr = paddr[term_host_pkg::FONT_REGION_BIT-1:2];
    assign font_data = pwdata[term_geom_pkg::GLYPH_W-1:0];

    assign busy   = code_valid | engine_busy;
    assign prdata = (access && !pwrite && hit_status) ?
                    {2'b00, scroll_line, 4'h0, cur_row, 2'b00, cur_col, 7'h00, busy} : 32'h0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            code_valid <= 1'b0;
        else if (char_accept)
            code_valid <= 1'b1;
        else if (code_ready)
            code_valid <= 1'b0;   // Taken by the cursor stage
    end

    always_ff @(posedge clk)
    begin
        if (char_accept)
            code <= pwdata[6:0];
    end

    // A stalled access must stay on the bus unchanged until pready
    a_stall_held: assert property (@(posedge clk) disable iff (!rst_n)
        access && !pready |=> access && $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

`default_nettype wire

// ==== source/term_cursor.sv ====
`timescale 1ns/1ps
`default_nettype none

module term_cursor (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    code_valid,
    input  logic [6:0]                              code,
    input  logic                                    cell_ready,
    output logic                                    code_ready,
    output logic                                    cell_valid,
    output logic [term_geom_pkg::COL_W-1:0]         cell_col,
    output logic [term_geom_pkg::ROW_W-1:0]         cell_row,
    output logic [6:0]                              cell_glyph,
    output logic                                    cell_blank,
    output logic [term_geom_pkg::COL_W-1:0]         cur_col,
    output logic [term_geom_pkg::ROW_W-1:0]         cur_row,
    output logic [term_geom_pkg::SCROLL_W-1:0]      scroll_line,
    output logic                                    engine_busy
);

    typedef enum logic [1:0] {S_IDLE, S_DRAW, S_MOVE} state_t;

    state_t state;
    logic code_fire, cell_fire, printing;
    logic op_right, op_left, op_enter, op_down, op_up, op_home, op_end, op_bs;
    logic [term_geom_pkg::COL_W-1:0]    nxt_col;
    logic [term_geom_pkg::ROW_W-1:0]    nxt_row;
    logic [term_geom_pkg::SCROLL_W-1:0] nxt_scroll;

    assign code_ready  = (state == S_IDLE);
    assign code_fire   = code_valid & code_ready;
    assign cell_fire   = cell_valid & cell_ready;
    assign printing    = (code >= term_geom_pkg::FIRST_PRINT) && (code <= term_geom_pkg::LAST_PRINT);
    assign engine_busy = (state != S_IDLE) || !cell_ready;   // Renderer still walking a glyph

    // Chained moves: RIGHT at the edge becomes ENTER, ENTER implies DOWN, LEFT at 0 implies UP
    assign op_bs    = code_fire && (code == term_host_pkg::C_BACKSPACE);
    assign op_home  = code_fire && (code == term_host_pkg::C_HOME);
    assign op_end   = code_fire && (code == term_host_pkg::C_END);
    assign op_right = (state == S_MOVE) || (code_fire && (code == term_host_pkg::C_RIGHT));
    assign op_left  = op_bs || (code_fire && (code == term_host_pkg::C_LEFT));
    assign op_enter = (code_fire && (code == term_host_pkg::C_ENTER)) ||
                      (op_right && (cur_col == term_geom_pkg::LAST_COL));
    assign op_down  = (code_fire && (code == term_host_pkg::C_DOWN)) || op_enter;
    assign op_up    = (code_fire && (code == term_host_pkg::C_UP)) || (op_left && (cur_col == '0));

    always_comb
    begin
        nxt_col    = cur_col;
        nxt_row    = cur_row;
        nxt_scroll = scroll_line;
        if (op_enter || op_home)
            nxt_col = '0;
        else if (op_right)
            nxt_col = cur_col + 1'b1;
        else if (op_left)
            nxt_col = (cur_col == '0) ? term_geom_pkg::LAST_COL : cur_col - 1'b1;
        else if (op_end)
            nxt_col = term_geom_pkg::LAST_COL;

        if (op_down)
        begin
            if (cur_row == term_geom_pkg::LAST_ROW)
                nxt_scroll = scroll_line + 1'b1;   // Bottom row, scroll instead
            else
                nxt_row = cur_row + 1'b1;
        end
        else if (op_up)
        begin
            if (cur_row == '0)
                nxt_scroll = scroll_line - 1'b1;
            else
                nxt_row = cur_row - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= S_IDLE;
            cell_valid  <= 1'b0;
            cur_col     <= '0;
            cur_row     <= '0;
            scroll_line <= '0;
        end
        else
        begin
            cur_col     <= nxt_col;
            cur_row     <= nxt_row;
            scroll_line <= nxt_scroll;
            case (state)
                S_IDLE:
                begin
                    if (code_fire && (printing || op_bs))
                    begin
                        cell_valid <= 1'b1;
                        state      <= S_DRAW;
                    end
                end
                S_DRAW:
                begin
                    if (cell_fire)
                    begin
                        cell_valid <= 1'b0;
                        state      <= cell_blank ? S_IDLE : S_MOVE;   // Backspace stays put
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Draw job payload, backspace uses the position after its LEFT step
    always_ff @(posedge clk)
    begin
        if (code_fire)
        begin
            cell_col   <= nxt_col;
            cell_row   <= nxt_row;
            cell_glyph <= printing ? code - term_geom_pkg::FIRST_PRINT : 7'h00;
            cell_blank <= !printing;
        end
    end

    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        cur_col <= term_geom_pkg::LAST_COL);
    a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
        cur_row <= term_geom_pkg::LAST_ROW);

endmodule

`default_nettype wire

// ==== source/term_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module term_render (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cell_valid,
    input  logic [term_geom_pkg::COL_W-1:0]         cell_col,
    input  logic [term_geom_pkg::ROW_W-1:0]         cell_row,
    input  logic [6:0]                              cell_glyph,
    input  logic                                    cell_blank,
    input  logic                                    font_we,
    input  logic [term_geom_pkg::FONT_ADDR_W-1:0]   font_addr,
    input  logic [term_geom_pkg::GLYPH_W-1:0]       font_data,
    input  logic                                    pix_ready,
    output logic                                    cell_ready,
    output logic                                    pix_valid,
    output logic [term_geom_pkg::PIX_X_W-1:0]       pix_x,
    output logic [term_geom_pkg::PIX_Y_W-1:0]       pix_y,
    output logic                                    pix_on
);

    logic [term_geom_pkg::GLYPH_W-1:0] font_mem [term_geom_pkg::FONT_DEPTH];
    logic [term_geom_pkg::GLYPH_W-1:0] font_q;   // Row of the current pixel

    logic [term_geom_pkg::PIX_IDX_W-1:0] pix_idx;
    logic [term_geom_pkg::PIX_IDX_W-1:0] idx_nxt;
    logic [term_geom_pkg::COL_W-1:0]     col_q;
    logic [term_geom_pkg::ROW_W-1:0]     row_q;
    logic [6:0]                          glyph_q;
    logic                                blank_q;
    logic start, advance, last;
    logic [term_geom_pkg::FONT_ADDR_W-1:0] rd_addr;

    assign cell_ready = !pix_valid;
    assign start      = cell_valid & cell_ready;
    assign advance    = pix_valid & pix_ready;
    assign last       = (pix_idx == term_geom_pkg::LAST_PIX);
    assign idx_nxt    = pix_idx + 1'b1;

    // Glyph index times 16 plus row
    assign rd_addr = start ? {cell_glyph, 4'h0} : {glyph_q, idx_nxt[6:3]};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < term_geom_pkg::FONT_DEPTH; i++)
                font_mem[i] <= '0;
        end
        else if (font_we && (font_addr < term_geom_pkg::FONT_END))
            font_mem[font_addr] <= font_data;
    end

    always_ff @(posedge clk)
    begin
        if (start || (advance && !last))
            font_q <= font_mem[rd_addr];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pix_valid <= 1'b0;
            pix_idx   <= '0;
        end
        else if (start)
        begin
            pix_valid <= 1'b1;
            pix_idx   <= '0;
        end
        else if (advance)
        begin
            pix_valid <= !last;   // Job ends on the 128th handshake
            pix_idx   <= idx_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            col_q   <= cell_col;
            row_q   <= cell_row;
            glyph_q <= cell_glyph;
            blank_q <= cell_blank;
        end
    end

    assign pix_x  = {col_q, pix_idx[2:0]};
    assign pix_y  = {row_q, pix_idx[6:3]};
    assign pix_on = !blank_q && font_q[~pix_idx[2:0]];   // MSB is the leftmost pixel

    a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable({pix_x, pix_y, pix_on}));

endmodule

`default_nettype wire

// ==== source/term_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module term_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [term_host_pkg::APB_ADDR_W-1:0]    paddr,
    input  logic [31:0]                             pwdata,
    input  logic                                    pix_ready,
    output logic [31:0]                             prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    pix_valid,
    output logic [term_geom_pkg::PIX_X_W-1:0]       pix_x,
    output logic [term_geom_pkg::PIX_Y_W-1:0]       pix_y,
    output logic                                    pix_on
);

    logic                                   code_valid, code_ready;
    logic [6:0]                             code;
    logic                                   cell_valid, cell_ready, cell_blank;
    logic [term_geom_pkg::COL_W-1:0]        cell_col, cur_col;
    logic [term_geom_pkg::ROW_W-1:0]        cell_row, cur_row;
    logic [6:0]                             cell_glyph;
    logic [term_geom_pkg::SCROLL_W-1:0]     scroll_line;
    logic                                   engine_busy;
    logic                                   font_we;
    logic [term_geom_pkg::FONT_ADDR_W-1:0]  font_addr;
    logic [term_geom_pkg::GLYPH_W-1:0]      font_data;

    // Host side, holding register and font forwarding
    term_apb_regs i_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .code_ready(code_ready), .engine_busy(engine_busy),
        .cur_col(cur_col), .cur_row(cur_row), .scroll_line(scroll_line),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .code_valid(code_valid), .code(code),
        .font_we(font_we), .font_addr(font_addr), .font_data(font_data)
    );

    term_cursor i_cursor (
        .clk(clk), .rst_n(rst_n),
        .code_valid(code_valid), .code(code), .cell_ready(cell_ready),
        .code_ready(code_ready), .cell_valid(cell_valid),
        .cell_col(cell_col), .cell_row(cell_row), .cell_glyph(cell_glyph),
        .cell_blank(cell_blank),
        .cur_col(cur_col), .cur_row(cur_row), .scroll_line(scroll_line),
        .engine_busy(engine_busy)
    );

    term_render i_render (
        .clk(clk), .rst_n(rst_n),
        .cell_valid(cell_valid), .cell_col(cell_col), .cell_row(cell_row),
        .cell_glyph(cell_glyph), .cell_blank(cell_blank),
        .font_we(font_we), .font_addr(font_addr), .font_data(font_data),
        .pix_ready(pix_ready), .cell_ready(cell_ready),
        .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y), .pix_on(pix_on)
    );

endmodule

`default_nettype wire

// ==== verif/term_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module term_tb;

    localparam int PIX_BITS = term_geom_pkg::PIX_X_W + term_geom_pkg::PIX_Y_W + 1;
    localparam int N_TESTS  = 18;

    typedef struct packed {
        logic [6:0] code;
        logic       rnd;    // Random pix_ready
        logic [7:0] reps;   // Writes issued back to back
    } test_t;

    test_t tests [N_TESTS] = '{
        '{7'h41, 1'b0, 8'd1}, '{7'h62, 1'b1, 8'd1},
        '{term_host_pkg::C_RIGHT, 1'b0, 8'd1}, '{term_host_pkg::C_HOME, 1'b0, 8'd1},
        '{term_host_pkg::C_LEFT, 1'b0, 8'd1},  '{term_host_pkg::C_RIGHT, 1'b0, 8'd1},
        '{term_host_pkg::C_UP, 1'b0, 8'd1},    '{term_host_pkg::C_UP, 1'b0, 8'd1},
        '{term_host_pkg::C_DOWN, 1'b0, 8'd1},  '{term_host_pkg::C_END, 1'b0, 8'd1},
        '{7'h1B, 1'b0, 8'd1},                  '{7'h41, 1'b0, 8'd1},
        '{7'h5A, 1'b1, 8'd41},                 '{term_host_pkg::C_ENTER, 1'b0, 8'd16},
        '{term_host_pkg::C_BACKSPACE, 1'b0, 8'd1}, '{term_host_pkg::C_BACKSPACE, 1'b1, 8'd1},
        '{7'h7E, 1'b1, 8'd3},                  '{7'h20, 1'b0, 8'd1}
    };

    logic clk = 1'b0, rst_n = 1'b0;
    logic psel = 1'b0, penable = 1'b0, pwrite = 1'b0, pix_ready = 1'b1;
    logic [term_host_pkg::APB_ADDR_W-1:0] paddr = '0;
    logic [31:0] pwdata = '0, prdata;
    logic pready, pslverr, pix_valid, pix_on;
    logic [term_geom_pkg::PIX_X_W-1:0] pix_x;
    logic [term_geom_pkg::PIX_Y_W-1:0] pix_y;

    logic [7:0] model_font [term_geom_pkg::FONT_DEPTH];
    logic [PIX_BITS-1:0] got_pix [$];
    logic [PIX_BITS-1:0] exp_pix [$];   // {x, y, on}
    logic [31:0] rng = 32'd66;
    logic rdy_random = 1'b0;
    int mx = 0, my = 0, ms = 0;
    int errors = 0, n_pass = 0, n_fail = 0, cycles = 0, limit = 1000000;

    term_top i_term_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        #1;
        if (rdy_random)
        begin
            rng = xorshift32(rng);
            pix_ready = rng[0];
        end
        else
            pix_ready = 1'b1;
    end

    // Record every pixel handshake mid-cycle
    always @(negedge clk)
        if (rst_n && pix_valid && pix_ready)
            got_pix.push_back({pix_x, pix_y, pix_on});

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] status_word();
        return {2'b00, 6'(ms), 4'h0, 4'(my), 2'b00, 6'(mx), 8'h00};
    endfunction

    // Called 1 ns after a rising edge, returns at the same point
    task automatic apb_access(input logic wr, input logic [13:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int stall);
        stall = 0;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            stall++;
            @(negedge clk);
        end
        rdata = prdata;
        assert (!pslverr)
        else
        begin
            $display("error: pslverr exp 0 got 1 at paddr %h", addr);
            errors++;
        end
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_glyph(input logic [6:0] c);
        int addr, stall;
        logic [31:0] rd;
        for (int r = 0; r < 16; r++)
        begin
            rng = xorshift32(rng);
            addr = (c - 32) * 16 + r;
            model_font[addr] = rng[7:0];
            apb_access(1'b1, {1'b1, 11'(addr), 2'b00}, {24'h0, rng[7:0]}, rd, stall);
        end
    endtask

    task automatic move_down();
        if (my < 14)
            my++;
        else
            ms = (ms + 1) % 64;
    endtask

    task automatic move_up();
        if (my > 0)
            my--;
        else
            ms = (ms + 63) % 64;
    endtask

    task automatic move_right();
        if (mx < 39)
            mx++;
        else
        begin
            mx = 0;   // Falls into ENTER
            move_down();
        end
    endtask

    task automatic move_left();
        if (mx > 0)
            mx--;
        else
        begin
            mx = 39;
            move_up();
        end
    endtask

    task automatic expect_glyph(input int g, input bit blank);
        logic [7:0] bits;
        for (int p = 0; p < 128; p++)
        begin
            bits = blank ? 8'h00 : model_font[g * 16 + p / 8];
            exp_pix.push_back({9'(mx * 8 + p % 8), 8'(my * 16 + p / 8), bits[7 - p % 8]});
        end
    endtask

    task automatic model_code(input logic [6:0] c);
        if (c >= 7'h20 && c <= 7'h7E)
        begin
            expect_glyph(c - 32, 1'b0);
            move_right();
        end
        else case (c)
            term_host_pkg::C_BACKSPACE:
            begin
                move_left();
                expect_glyph(0, 1'b1);
            end
            term_host_pkg::C_ENTER:
            begin
                mx = 0;
                move_down();
            end
            term_host_pkg::C_HOME:  mx = 0;
            term_host_pkg::C_END:   mx = 39;
            term_host_pkg::C_UP:    move_up();
            term_host_pkg::C_DOWN:  move_down();
            term_host_pkg::C_LEFT:  move_left();
            term_host_pkg::C_RIGHT: move_right();
            default: ;   // Ignored control code
        endcase
    endtask

    task automatic wait_idle(output logic [31:0] st);
        int stall;
        st = 32'h1;
        while (st[0])
            apb_access(1'b0, term_host_pkg::ADDR_STATUS, 32'h0, st, stall);
    endtask

    task automatic compare_pixels();
        bit ok;
        ok = 1'b1;
        assert (got_pix.size() == exp_pix.size())
        else
        begin
            $display("error: pix_valid handshake count exp %h got %h",
                     exp_pix.size(), got_pix.size());
            errors++;
        end
        for (int i = 0; i < exp_pix.size() && i < got_pix.size() && ok; i++)
            assert (got_pix[i] === exp_pix[i])
            else
            begin   // Fields x [17:9], y [8:1], on [0]
                $display("error: pix_x exp %h got %h pix_y exp %h got %h pix_on exp %h got %h",
                         exp_pix[i][17:9], got_pix[i][17:9], exp_pix[i][8:1],
                         got_pix[i][8:1], exp_pix[i][0], got_pix[i][0]);
                $display("  at pixel %0d", i);
                errors++;
                ok = 1'b0;
            end
    endtask

    initial
    begin
        int errs_before, stall, max_stall, total;
        logic [31:0] rd, st;
        total = 0;
        for (int t = 0; t < N_TESTS; t++)
            total += tests[t].reps + 1;   // One extra slot for font load and polling
        limit = total * (128 * 4 + 40);
        for (int i = 0; i < term_geom_pkg::FONT_DEPTH; i++)
            model_font[i] = 8'h00;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        errs_before = errors;
        apb_access(1'b0, term_host_pkg::ADDR_STATUS, 32'h0, rd, stall);
        assert (rd == 32'h0)
        else
        begin
            $display("error: prdata exp 00000000 got %h", rd);
            errors++;
        end
        assert (!pix_valid)
        else
        begin
            $display("error: pix_valid exp 0 got 1");
            errors++;
        end
        if (errors == errs_before)
            n_pass++;
        else
            n_fail++;
        $display("test reset status: %s", (errors == errs_before) ? "pass" : "fail");

        for (int t = 0; t < N_TESTS; t++)
            if (tests[t].code >= 7'h20 && tests[t].code <= 7'h7E)
                load_glyph(tests[t].code);

        for (int t = 0; t < N_TESTS; t++)
        begin
            errs_before = errors;
            max_stall = 0;
            got_pix.delete();
            exp_pix.delete();
            rdy_random = tests[t].rnd;
            for (int k = 0; k < tests[t].reps; k++)
            begin
                apb_access(1'b1, term_host_pkg::ADDR_CHAR, {25'h0, tests[t].code}, rd, stall);
                if (stall > max_stall)
                    max_stall = stall;
                model_code(tests[t].code);
            end
            wait_idle(st);
            compare_pixels();
            assert (st == status_word())
            else
            begin
                $display("error: prdata status exp %h got %h", status_word(), st);
                errors++;
            end
            if (tests[t].reps >= 3 && tests[t].code >= 7'h20)
                assert (max_stall > 0)
                else
                begin
                    $display("a character write during drawing was never held back");
                    errors++;
                end
            if (errors == errs_before)
                n_pass++;
            else
                n_fail++;
            $display("test %0d code %h x%0d: %s", t, tests[t].code, tests[t].reps,
                     (errors == errs_before) ? "pass" : "fail");
        end

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/term_geom_pkg.sv
source/term_host_pkg.sv
source/term_apb_regs.sv
source/term_cursor.sv
source/term_render.sv
source/term_top.sv
verif/term_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module term_tb \
    -o term_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/term_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
